// ==== iCachePkg.sv ====
`default_nettype none

package iCachePkg;

    // geometry
    localparam int numWays      = 4;
    localparam int numSets      = 64;
    localparam int wordsPerLine = 4;
    localparam int offsetBits   = 4;  // 16-byte lines
    localparam int indexBits    = 6;
    localparam int tagBits      = 22; // addr[31:10]

    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [indexBits-1:0] setIdxT;

    // word 0 sits in the low bits
    typedef logic [wordsPerLine*32-1:0] lineT;

    typedef logic [$clog2(numWays)-1:0] wayIdxT;
    typedef logic [numWays-1:0] wayMaskT;   // bit n is way n

    // tree pseudo-LRU, one per set
    // bit 0 root, bit 1 leaf for ways 0/1, bit 2 leaf for ways 2/3
    typedef logic [2:0] plruT;

    typedef enum logic [1:0] {
        sLookup,
        sRefill,
        sReplay
    } fetchStateT;

endpackage

`default_nettype wire

// ==== refillIf.sv ====
`default_nettype none

// one way write, shared by the tag and line stores
interface refillIf;

    logic              writeEn;   // single-cycle strobe
    iCachePkg::wayIdxT way;
    iCachePkg::setIdxT index;
    iCachePkg::tagT    tag;
    iCachePkg::lineT   line;

    modport ctrl (
        output writeEn, way, index, tag, line
    );

    modport tagSide (
        input writeEn, way, index, tag
    );

    modport lineSide (
        input writeEn, way, index, line
    );

endinterface

`default_nettype wire

// ==== tagStore.sv ====
`default_nettype none

module tagStore (
    input  wire                      clk,
    input  wire                      rst,
    input  wire iCachePkg::setIdxT   lookupIndex,
    input  wire iCachePkg::tagT      lookupTag,
    refillIf.tagSide                 refill,
    output wire iCachePkg::wayMaskT  hitWay
);

    iCachePkg::tagT tagReg;   // tag of the address now in compare

    always_ff @(posedge clk) begin
        tagReg <= lookupTag;
    end

    for (genvar w = 0; w < iCachePkg::numWays; w++) begin : wayGen
        iCachePkg::tagT                tagMem [iCachePkg::numSets];
        logic [iCachePkg::numSets-1:0] validBits;
        iCachePkg::tagT                tagRd;
        logic                          validRd;
        logic                          wayWrite;

        assign wayWrite = refill.writeEn && (refill.way == iCachePkg::wayIdxT'(w));

        // read old contents when index matches a write
        always_ff @(posedge clk) begin
            if (wayWrite) begin
                tagMem[refill.index] <= refill.tag;
            end
            tagRd <= tagMem[lookupIndex];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                validBits <= '0;
                validRd   <= 1'b0;
            end else begin
                if (wayWrite) begin
                    validBits[refill.index] <= 1'b1;
                end
                validRd <= validBits[lookupIndex];
            end
        end

        assign hitWay[w] = validRd && (tagRd == tagReg);
    end

endmodule

`default_nettype wire

// ==== lineStore.sv ====
`default_nettype none

module lineStore (
    input  wire                     clk,
    input  wire iCachePkg::setIdxT  lookupIndex,
    refillIf.lineSide               refill,
    output iCachePkg::lineT         wayLine0,
    output iCachePkg::lineT         wayLine1,
    output iCachePkg::lineT         wayLine2,
    output iCachePkg::lineT         wayLine3
);

    iCachePkg::lineT readLine [iCachePkg::numWays];

    // every way is read, the hit picks one after compare
    for (genvar w = 0; w < iCachePkg::numWays; w++) begin : wayGen
        iCachePkg::lineT lineMem [iCachePkg::numSets];
        logic            wayWrite;

        assign wayWrite = refill.writeEn && (refill.way == iCachePkg::wayIdxT'(w));

        always_ff @(posedge clk) begin
            if (wayWrite) begin
                lineMem[refill.index] <= refill.line;
            end
            readLine[w] <= lineMem[lookupIndex];
        end
    end

    assign wayLine0 = readLine[0];
    assign wayLine1 = readLine[1];
    assign wayLine2 = readLine[2];
    assign wayLine3 = readLine[3];

endmodule

`default_nettype wire

// ==== fetchControl.sv ====
`default_nettype none

module fetchControl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire iCachePkg::addrT     pc,
    input  wire iCachePkg::wayMaskT  hitWay,
    input  wire iCachePkg::lineT     wayLine0,
    input  wire iCachePkg::lineT     wayLine1,
    input  wire iCachePkg::lineT     wayLine2,
    input  wire iCachePkg::lineT     wayLine3,
    input  wire                      memRespValid,
    input  wire iCachePkg::lineT     memRespLine,
    output iCachePkg::setIdxT        lookupIndex,
    output iCachePkg::tagT           lookupTag,
    refillIf.ctrl                    refill,
    output logic                     stall,
    output logic                     memReq,
    output iCachePkg::addrT          memReqAddr,
    output iCachePkg::addrT          fetchPc,
    output iCachePkg::wordT          inst0,
    output iCachePkg::wordT          inst1,
    output logic                     inst0Valid,
    output logic                     inst1Valid
);

    iCachePkg::fetchStateT state;
    iCachePkg::fetchStateT nextState;

    iCachePkg::addrT   heldPc;      // address in compare stage
    logic              occupied;
    iCachePkg::setIdxT heldIndex;
    iCachePkg::tagT    heldTag;
    iCachePkg::addrT   lookupPc;

    iCachePkg::plruT   ages [iCachePkg::numSets];

    logic              lookupHit;
    logic              miss;
    logic              accept;
    logic              refillDone;
    iCachePkg::wayIdxT hitIdx;
    iCachePkg::wayIdxT victim;
    iCachePkg::wayIdxT touchWay;
    iCachePkg::lineT   hitLine;
    iCachePkg::wordT   lineWords [iCachePkg::wordsPerLine];

    // victim from the tree, walks away from the recent side
    function automatic iCachePkg::wayIdxT pickVictim(input iCachePkg::plruT age);
        if (age[0]) begin
            return age[1] ? 2'd0 : 2'd1;
        end
        return age[2] ? 2'd2 : 2'd3;
    endfunction

    // mark a way as most recently used
    function automatic iCachePkg::plruT touch(input iCachePkg::plruT age,
                                              input iCachePkg::wayIdxT way);
        iCachePkg::plruT next;
        next    = age;
        next[0] = way[1];
        if (way[1]) begin
            next[2] = way[0];
        end else begin
            next[1] = way[0];
        end
        return next;
    endfunction

    assign heldIndex = heldPc[iCachePkg::offsetBits +: iCachePkg::indexBits];
    assign heldTag   = heldPc[iCachePkg::offsetBits + iCachePkg::indexBits +: iCachePkg::tagBits];

    assign lookupHit  = (state == iCachePkg::sLookup) && occupied && (|hitWay);
    assign miss       = (state == iCachePkg::sLookup) && occupied && !(|hitWay);
    assign stall      = (state != iCachePkg::sLookup) || miss;
    assign accept     = !stall;
    assign refillDone = (state == iCachePkg::sRefill) && memRespValid;

    // held address is re-read while stalled
    assign lookupPc    = accept ? pc : heldPc;
    assign lookupIndex = lookupPc[iCachePkg::offsetBits +: iCachePkg::indexBits];
    assign lookupTag   = lookupPc[iCachePkg::offsetBits + iCachePkg::indexBits +: iCachePkg::tagBits];

    always_comb begin
        nextState = state;
        case (state)
            iCachePkg::sLookup: begin
                if (miss) begin
                    nextState = iCachePkg::sRefill;
                end
            end
            iCachePkg::sRefill: begin
                if (memRespValid) begin
                    nextState = iCachePkg::sReplay;
                end
            end
            iCachePkg::sReplay: begin
                nextState = iCachePkg::sLookup;
            end
            default: begin
                nextState = iCachePkg::sLookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= iCachePkg::sLookup;
            occupied <= 1'b0;
        end else begin
            state <= nextState;
            if (accept) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldPc <= pc;
        end
    end

    // hitting way number, at most one bit set
    always_comb begin
        hitIdx = '0;
        for (int w = 0; w < iCachePkg::numWays; w++) begin
            if (hitWay[w]) begin
                hitIdx = iCachePkg::wayIdxT'(w);
            end
        end
    end

    always_comb begin
        case (hitIdx)
            2'd0:    hitLine = wayLine0;
            2'd1:    hitLine = wayLine1;
            2'd2:    hitLine = wayLine2;
            default: hitLine = wayLine3;
        endcase
    end

    always_comb begin
        for (int k = 0; k < iCachePkg::wordsPerLine; k++) begin
            lineWords[k] = hitLine[32*k +: 32];
        end
    end

    assign victim   = pickVictim(ages[heldIndex]);
    assign touchWay = refillDone ? victim : hitIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < iCachePkg::numSets; s++) begin
                ages[s] <= '0;
            end
        end else if (lookupHit || refillDone) begin
            ages[heldIndex] <= touch(ages[heldIndex], touchWay);
        end
    end

    assign refill.writeEn = refillDone;
    assign refill.way     = victim;
    assign refill.index   = heldIndex;
    assign refill.tag     = heldTag;
    assign refill.line    = memRespLine;

    assign memReq     = miss;  // only one compare cycle per miss
    assign memReqAddr = {heldPc[31:iCachePkg::offsetBits], {iCachePkg::offsetBits{1'b0}}};

    assign fetchPc    = {heldPc[31:3], 3'b000};
    assign inst0      = lineWords[{heldPc[3], 1'b0}];
    assign inst1      = lineWords[{heldPc[3], 1'b1}];
    assign inst0Valid = lookupHit && !heldPc[2];
    assign inst1Valid = lookupHit;

endmodule

`default_nettype wire

// ==== iCache.sv ====
`default_nettype none

module iCache (
    input  wire                   clk,
    input  wire                   rst,
    input  wire iCachePkg::addrT  pc,
    input  wire                   memRespValid,
    input  wire iCachePkg::lineT  memRespLine,
    output logic                  stall,
    output logic                  memReq,
    output iCachePkg::addrT       memReqAddr,
    output iCachePkg::addrT       fetchPc,
    output iCachePkg::wordT       inst0,
    output iCachePkg::wordT       inst1,
    output logic                  inst0Valid,
    output logic                  inst1Valid
);

    iCachePkg::setIdxT   lookupIndex;
    iCachePkg::tagT      lookupTag;
    iCachePkg::wayMaskT  hitWay;
    iCachePkg::lineT     wayLine0;
    iCachePkg::lineT     wayLine1;
    iCachePkg::lineT     wayLine2;
    iCachePkg::lineT     wayLine3;

    refillIf refillBus ();

    tagStore tagMemory (
        .clk         (clk),
        .rst         (rst),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .refill      (refillBus.tagSide),
        .hitWay      (hitWay)
    );

    lineStore lineMemory (
        .clk         (clk),
        .lookupIndex (lookupIndex),
        .refill      (refillBus.lineSide),
        .wayLine0    (wayLine0),
        .wayLine1    (wayLine1),
        .wayLine2    (wayLine2),
        .wayLine3    (wayLine3)
    );

    fetchControl control (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .hitWay       (hitWay),
        .wayLine0     (wayLine0),
        .wayLine1     (wayLine1),
        .wayLine2     (wayLine2),
        .wayLine3     (wayLine3),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .lookupIndex  (lookupIndex),
        .lookupTag    (lookupTag),
        .refill       (refillBus.ctrl),
        .stall        (stall),
        .memReq       (memReq),
        .memReqAddr   (memReqAddr),
        .fetchPc      (fetchPc),
        .inst0        (inst0),
        .inst1        (inst1),
        .inst0Valid   (inst0Valid),
        .inst1Valid   (inst1Valid)
    );

endmodule

`default_nettype wire

// ==== memResponder.sv ====
`default_nettype none

// line memory stand-in for the cache refill port
module memResponder (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   memReq,
    input  wire iCachePkg::addrT  memReqAddr,
    output logic                  memRespValid,
    output iCachePkg::lineT       memRespLine,
    output int                    reqCount
);
    timeunit 1ns;
    timeprecision 100ps;

    logic            pending;
    int              waitCycles;
    iCachePkg::addrT pendAddr;

    // word k of line A holds (A + 4k) ^ 5a5a0000
    function automatic iCachePkg::lineT makeLine(input iCachePkg::addrT a);
        iCachePkg::lineT l;
        for (int k = 0; k < iCachePkg::wordsPerLine; k++) begin
            l[32*k +: 32] = (a + 32'(4 * k)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    initial begin
        memRespValid = 1'b0;
        memRespLine  = '0;
        reqCount     = 0;
        pending      = 1'b0;
        waitCycles   = 0;
        pendAddr     = '0;
    end

    always @(negedge clk) begin
        memRespValid <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
        end else if (memReq) begin
            reqCount   <= reqCount + 1;
            pending    <= 1'b1;
            pendAddr   <= memReqAddr;
            waitCycles <= $urandom_range(1, 8);
        end else if (pending) begin
            if (waitCycles == 1) begin
                memRespValid <= 1'b1;   // one cycle only
                memRespLine  <= makeLine(pendAddr);
                pending      <= 1'b0;
            end
            waitCycles <= waitCycles - 1;
        end
    end

endmodule

`default_nettype wire

// ==== iCacheTb.sv ====
`default_nettype none

module iCacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numFetches = 32;
    localparam int maxWait    = 40;   // cycles per fetch before giving up
    localparam int timeoutNs  = (numFetches * 20 + 60) * 10;

    logic            clk;
    logic            rst;
    iCachePkg::addrT pc;
    logic            memRespValid;
    iCachePkg::lineT memRespLine;
    logic            stall;
    logic            memReq;
    iCachePkg::addrT memReqAddr;
    iCachePkg::addrT fetchPc;
    iCachePkg::wordT inst0;
    iCachePkg::wordT inst1;
    logic            inst0Valid;
    logic            inst1Valid;
    int              reqCount;

    int errors = 0;
    int checks = 0;

    // reference cache state
    logic [21:0]     refTag   [64][4];
    logic            refValid [64][4];
    iCachePkg::plruT refAge   [64];

    iCache iCache_i (
        .clk(clk), .rst(rst), .pc(pc),
        .memRespValid(memRespValid), .memRespLine(memRespLine),
        .stall(stall), .memReq(memReq), .memReqAddr(memReqAddr),
        .fetchPc(fetchPc), .inst0(inst0), .inst1(inst1),
        .inst0Valid(inst0Valid), .inst1Valid(inst1Valid)
    );

    memResponder memory (
        .clk(clk), .rst(rst), .memReq(memReq), .memReqAddr(memReqAddr),
        .memRespValid(memRespValid), .memRespLine(memRespLine), .reqCount(reqCount)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        #(timeoutNs);
        $display("watchdog expired, the cache never finished the test sequence");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic iCachePkg::wordT expWord(input iCachePkg::addrT a, input int k);
        return ({a[31:4], 4'h0} + 32'(4 * k)) ^ 32'h5a5a0000;
    endfunction

    function automatic void clearModel();
        for (int s = 0; s < 64; s++) begin
            refAge[s] = '0;
            for (int w = 0; w < 4; w++) begin
                refValid[s][w] = 1'b0;
                refTag[s][w]   = '0;
            end
        end
    endfunction

    // predicts a miss and updates tags and ages
    function automatic bit predictAccess(input iCachePkg::addrT a);
        int  s;
        int  way;
        bit  miss;
        s    = int'(a[9:4]);
        way  = -1;
        miss = 1'b0;
        for (int w = 0; w < 4; w++) begin
            if (refValid[s][w] && refTag[s][w] == a[31:10]) begin
                way = w;
            end
        end
        if (way < 0) begin
            miss = 1'b1;
            case ({refAge[s][0], refAge[s][1], refAge[s][2]})
                3'b110, 3'b111: way = 0;
                3'b100, 3'b101: way = 1;
                3'b001, 3'b011: way = 2;
                default:        way = 3;
            endcase
            refTag[s][way]   = a[31:10];
            refValid[s][way] = 1'b1;
        end
        case (way)
            0: begin
                refAge[s][0] = 1'b0;
                refAge[s][1] = 1'b0;
            end
            1: begin
                refAge[s][0] = 1'b0;
                refAge[s][1] = 1'b1;
            end
            2: begin
                refAge[s][0] = 1'b1;
                refAge[s][2] = 1'b0;
            end
            default: begin
                refAge[s][0] = 1'b1;
                refAge[s][2] = 1'b1;
            end
        endcase
        return miss;
    endfunction

    // entered on a falling edge with stall low
    task automatic fetchCheck(input iCachePkg::addrT a);
        bit              expMiss;
        int              cycles;
        int              reqBefore;
        logic            sawReq;
        iCachePkg::addrT reqAddr;
        expMiss   = predictAccess(a);
        reqBefore = reqCount;
        sawReq    = 1'b0;
        reqAddr   = '0;
        cycles    = 0;
        pc        = a;
        @(posedge clk);
        do begin
            @(negedge clk);
            cycles++;
            if (memReq) begin
                sawReq  = 1'b1;
                reqAddr = memReqAddr;
            end
        end while (stall && cycles < maxWait);
        assert (!stall) else begin
            errors++;
            $display("stall stuck high at %0t for address %h", $time, a);
        end
        if (expMiss) begin
            checkValue("memReq seen", 32'(sawReq), 32'd1);
            checkValue("memReqAddr", reqAddr, a & 32'hffff_fff0);
        end else begin
            checkValue("hit latency", cycles, 32'd1);
        end
        checkValue("request count delta", reqCount - reqBefore, expMiss ? 32'd1 : 32'd0);
        checkValue("fetchPc", fetchPc, a & 32'hffff_fff8);
        checkValue("inst0Valid", 32'(inst0Valid), 32'(!a[2]));
        checkValue("inst1Valid", 32'(inst1Valid), 32'd1);
        checkValue("inst0", inst0, expWord(a, a[3] ? 2 : 0));
        checkValue("inst1", inst1, expWord(a, a[3] ? 3 : 1));
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        clearModel();
    endtask

    task automatic coldMiss();
        fetchCheck(32'h0000_1000);
    endtask

    task automatic streamingHits();
        fetchCheck(32'h0000_1004);
        fetchCheck(32'h0000_1008);
        fetchCheck(32'h0000_100c);
    endtask

    task automatic wordSelect();
        fetchCheck(32'h0000_204c);   // bit 3 and bit 2 set
        fetchCheck(32'h0000_2040);
        fetchCheck(32'h0000_2048);
        fetchCheck(32'h0000_2044);
    endtask

    task automatic associativity();
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 1; t <= 4; t++) begin
                fetchCheck({22'(t), 6'd5, 4'h0});
            end
        end
    endtask

    task automatic replacement();
        int order [4] = '{13, 11, 14, 12};
        for (int t = 11; t <= 14; t++) begin
            fetchCheck({22'(t), 6'd9, 4'h8});
        end
        foreach (order[i]) begin
            fetchCheck({22'(order[i]), 6'd9, 4'h0});
        end
        fetchCheck({22'd15, 6'd9, 4'h4});   // evicts the least recent way
        for (int t = 11; t <= 15; t++) begin
            fetchCheck({22'(t), 6'd9, 4'h0});
        end
    endtask

    task automatic resetClears();
        fetchCheck(32'h0000_1000);
        applyReset();
        fetchCheck(32'h0000_1000);   // must miss again
    endtask

    initial begin
        void'($urandom(32'hcdcb));
        pc = '0;
        clearModel();
        applyReset();
        coldMiss();
        streamingHits();
        wordSelect();
        associativity();
        replacement();
        resetClears();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
iCachePkg.sv
refillIf.sv
tagStore.sv
lineStore.sv
fetchControl.sv
iCache.sv
memResponder.sv
iCacheTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= iCacheTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
